//--- common/actPkg.sv
// Activation fetch package
// Counter widths, APB register map and the structs passed between
// the loop, address and buffer stages
package actPkg;

    localparam int RowCntW  = 5;    // Column and row counters
    localparam int BlkCntW  = 4;
    localparam int FrmCntW  = 4;
    localparam int PatCntW  = 4;
    localparam int GrpCntW  = 4;
    localparam int ActAddrW = 9;    // 512 buffer words

    // ==============================
    // Register map
    // ==============================
    localparam logic [11:0] RegCtrl      = 12'h000;   // Bit 0 start
    localparam logic [11:0] RegStatus    = 12'h004;   // Bit 0 busy, bit 1 done
    localparam logic [11:0] RegGeom      = 12'h008;
    localparam logic [11:0] RegLoop      = 12'h00C;
    localparam logic [11:0] RegPatStride = 12'h010;
    localparam logic [11:0] BufBase      = 12'h800;   // One word per 4 bytes

    // Field positions in RegGeom and RegLoop
    localparam int GeomBlkLsb   = 8;
    localparam int GeomFrmLsb   = 16;
    localparam int LoopGrpLsb   = 8;
    localparam int LoopOrderBit = 16;

    // All counts hold the real value minus one
    typedef struct packed {
        logic [RowCntW-1:0]  lenRow;
        logic [BlkCntW-1:0]  numBlk;
        logic [FrmCntW-1:0]  numFrm;
        logic [PatCntW-1:0]  numPat;
        logic [GrpCntW-1:0]  numFtrGrp;
        logic                patchFirst;
        logic [ActAddrW-1:0] patStride;
    } loopCfg_t;

    typedef struct packed {
        logic firstRow;
        logic lastRow;
        logic valCol;
        logic valPsum;
        logic lastBlk;
        logic evenFrm;
        logic lastLay;
    } actFlags_t;

    typedef struct packed {
        logic [RowCntW-1:0] col;
        logic [RowCntW-1:0] row;
        logic [BlkCntW-1:0] blk;
        logic [FrmCntW-1:0] frm;
        logic [PatCntW-1:0] pat;
        logic [GrpCntW-1:0] grp;
        actFlags_t          flags;
    } actIdx_t;

    typedef struct packed {
        logic [ActAddrW-1:0] addr;
        logic [PatCntW-1:0]  pat;
        logic [GrpCntW-1:0]  grp;
        actFlags_t           flags;
    } actAddr_t;

endpackage

//--- common/actStreamIf.sv
// Valid/ready stream between pipeline stages
// The payload type is set per instance, an item moves on a clock
// edge where valid and ready are both high
`timescale 1ns/1ps

interface actStreamIf #(
    parameter type PayloadT = logic
) ();

    logic    valid;
    logic    ready;
    PayloadT payload;

    // Sender side
    modport src (
        output valid,
        output payload,
        input  ready
    );

    // Receiver side
    modport snk (
        input  valid,
        input  payload,
        output ready
    );

endinterface

//--- verilog/actCfgRegs.sv
// APB register block of the activation fetch engine
// Holds the loop geometry, issues the start pulse, keeps the sticky
// done bit and forwards buffer window writes while the engine is idle
`timescale 1ns/1ps

module actCfgRegs #(
    parameter int ActWidth = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [11:0]                 paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output actPkg::loopCfg_t            cfg,
    output logic                        start,
    input  logic                        busy,
    input  logic                        layerDone,
    output logic                        bufWr,
    output logic [actPkg::ActAddrW-1:0] bufWrAddr,
    output logic [ActWidth-1:0]         bufWrData
);

    logic wrAccess;
    logic running;      // From start until layerDone
    logic done;
    logic idle;

    assign wrAccess = psel && penable && pwrite;
    assign idle     = !running && !busy;   // Nothing left in the pipe

    // ==============================
    // Config registers and start
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= wrAccess && (paddr == actPkg::RegCtrl) && pwdata[0] && idle;
            if (wrAccess) begin
                case (paddr)
                    actPkg::RegGeom: begin
                        cfg.lenRow <= pwdata[0 +: actPkg::RowCntW];
                        cfg.numBlk <= pwdata[actPkg::GeomBlkLsb +: actPkg::BlkCntW];
                        cfg.numFrm <= pwdata[actPkg::GeomFrmLsb +: actPkg::FrmCntW];
                    end
                    actPkg::RegLoop: begin
                        cfg.numPat     <= pwdata[0 +: actPkg::PatCntW];
                        cfg.numFtrGrp  <= pwdata[actPkg::LoopGrpLsb +: actPkg::GrpCntW];
                        cfg.patchFirst <= pwdata[actPkg::LoopOrderBit];
                    end
                    actPkg::RegPatStride: cfg.patStride <= pwdata[0 +: actPkg::ActAddrW];
                    default: ;
                endcase
            end
        end
    end

    // Status, done stays set until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            done    <= 1'b0;
        end else if (layerDone) begin
            running <= 1'b0;
            done    <= 1'b1;
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            actPkg::RegStatus: begin
                prdata[0] = running;
                prdata[1] = done;
            end
            actPkg::RegGeom: begin
                prdata[0 +: actPkg::RowCntW]                 = cfg.lenRow;
                prdata[actPkg::GeomBlkLsb +: actPkg::BlkCntW] = cfg.numBlk;
                prdata[actPkg::GeomFrmLsb +: actPkg::FrmCntW] = cfg.numFrm;
            end
            actPkg::RegLoop: begin
                prdata[0 +: actPkg::PatCntW]                  = cfg.numPat;
                prdata[actPkg::LoopGrpLsb +: actPkg::GrpCntW] = cfg.numFtrGrp;
                prdata[actPkg::LoopOrderBit]                  = cfg.patchFirst;
            end
            actPkg::RegPatStride: prdata[0 +: actPkg::ActAddrW] = cfg.patStride;
            default: ;
        endcase
    end

    // Buffer window, word address from byte address
    assign bufWr     = wrAccess && (paddr >= actPkg::BufBase) && idle;
    assign bufWrAddr = paddr[2 +: actPkg::ActAddrW];
    assign bufWrData = pwdata[ActWidth-1:0];

endmodule

//--- actCtrl/actLoopCtrl.sv
// Activation loop controller
// Walks column, row, block and frame loops, then the patch and
// filter-group loops in the order chosen by patchFirst. Each
// accepted step issues the next index item with its loop flags
`timescale 1ns/1ps

module actLoopCtrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  actPkg::loopCfg_t cfg,
    output logic             busy,
    actStreamIf.src          idxOut
);

    logic [actPkg::RowCntW-1:0] col;
    logic [actPkg::RowCntW-1:0] row;
    logic [actPkg::BlkCntW-1:0] blk;
    logic [actPkg::FrmCntW-1:0] frm;
    logic [actPkg::PatCntW-1:0] pat;
    logic [actPkg::GrpCntW-1:0] grp;
    logic                       running;
    logic                       step;
    logic                       lastRowItem;
    logic                       lastBlkItem;
    logic                       lastFrmItem;
    logic                       lastPatItem;
    logic                       lastPat;
    logic                       lastGrp;
    logic                       lastLay;
    actPkg::actIdx_t            item;

    assign step = idxOut.valid && idxOut.ready;

    // ==============================
    // Loop end detection
    // ==============================
    assign lastRowItem = col == cfg.lenRow;
    assign lastBlkItem = lastRowItem && (row == cfg.lenRow);  // Square block
    assign lastFrmItem = lastBlkItem && (blk == cfg.numBlk);
    assign lastPatItem = lastFrmItem && (frm == cfg.numFrm);
    assign lastPat     = pat == cfg.numPat;
    assign lastGrp     = grp == cfg.numFtrGrp;
    assign lastLay     = lastPatItem && lastPat && lastGrp;   // Same in both orders

    // ==============================
    // Counters
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            col     <= '0;
            row     <= '0;
            blk     <= '0;
            frm     <= '0;
            pat     <= '0;
            grp     <= '0;
        end else if (start) begin
            running <= 1'b1;
            col     <= '0;
            row     <= '0;
            blk     <= '0;
            frm     <= '0;
            pat     <= '0;
            grp     <= '0;
        end else if (step) begin
            if (lastLay) begin
                running <= 1'b0;
            end
            col <= lastRowItem ? '0 : col + 1'b1;
            if (lastRowItem) begin
                row <= lastBlkItem ? '0 : row + 1'b1;
            end
            if (lastBlkItem) begin
                blk <= lastFrmItem ? '0 : blk + 1'b1;
            end
            if (lastFrmItem) begin
                frm <= lastPatItem ? '0 : frm + 1'b1;
            end
            // Patch done, the inner of the two outer loops moves
            if (lastPatItem) begin
                if (cfg.patchFirst) begin
                    pat <= lastPat ? '0 : pat + 1'b1;
                    if (lastPat) begin
                        grp <= lastGrp ? '0 : grp + 1'b1;
                    end
                end else begin
                    grp <= lastGrp ? '0 : grp + 1'b1;
                    if (lastGrp) begin
                        pat <= lastPat ? '0 : pat + 1'b1;
                    end
                end
            end
        end
    end

    // Item built straight from the counters
    always_comb begin
        item.col            = col;
        item.row            = row;
        item.blk            = blk;
        item.frm            = frm;
        item.pat            = pat;
        item.grp            = grp;
        item.flags.firstRow = col == '0;
        item.flags.lastRow  = lastRowItem;
        item.flags.valCol   = col >= 2;    // First two columns only prime the PE
        item.flags.valPsum  = row >= 2;
        item.flags.lastBlk  = lastBlkItem;
        item.flags.evenFrm  = !frm[0];
        item.flags.lastLay  = lastLay;
    end

    assign idxOut.valid   = running;
    assign idxOut.payload = item;
    assign busy           = running;

    // Held item must not change under back-pressure
    stableUnderStall: assert property (@(posedge clk) disable iff (!rst_n)
        idxOut.valid && !idxOut.ready |=> idxOut.valid && $stable(idxOut.payload));

endmodule

//--- actCtrl/actAddrGen.sv
// Activation address stage
// Turns loop indices into a buffer address: frame, block, row and
// column linear position plus the patch offset, wrapped to the
// buffer size. One register stage with full throughput
`timescale 1ns/1ps

module actAddrGen (
    input  logic             clk,
    input  logic             rst_n,
    input  actPkg::loopCfg_t cfg,
    actStreamIf.snk          idxIn,
    actStreamIf.src          addrOut
);

    localparam int AW = actPkg::ActAddrW;

    actPkg::actIdx_t  idx;
    actPkg::actAddr_t outQ;
    logic [AW-1:0]    rowLen;
    logic [AW-1:0]    blkSize;
    logic [AW-1:0]    blkIdx;
    logic [AW-1:0]    linAddr;
    logic [AW-1:0]    patOff;
    logic             outValid;
    logic             load;

    assign idx = idxIn.payload;

    // ==============================
    // Address arithmetic, modulo 2**AW
    // ==============================
    assign rowLen  = AW'(cfg.lenRow) + 1'b1;
    assign blkSize = rowLen * rowLen;
    assign blkIdx  = AW'(idx.frm) * (AW'(cfg.numBlk) + 1'b1) + AW'(idx.blk);
    assign linAddr = blkIdx * blkSize + AW'(idx.row) * rowLen + AW'(idx.col);
    assign patOff  = cfg.patStride * AW'(idx.pat);

    // Take a new item when empty or the held one leaves
    assign idxIn.ready = !outValid || addrOut.ready;
    assign load        = idxIn.valid && idxIn.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
        end else if (idxIn.ready) begin
            outValid <= idxIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outQ.addr  <= linAddr + patOff;
            outQ.pat   <= idx.pat;
            outQ.grp   <= idx.grp;
            outQ.flags <= idx.flags;   // Flags ride along unchanged
        end
    end

    assign addrOut.valid   = outValid;
    assign addrOut.payload = outQ;

endmodule

//--- verilog/actBuffer.sv
// Activation buffer stage
// 512-word RAM written from the APB window and read by the address
// stream. The registered read is the output stage, a skid entry in
// front of it keeps the upstream ready registered
`timescale 1ns/1ps

module actBuffer #(
    parameter int ActWidth = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        bufWr,
    input  logic [actPkg::ActAddrW-1:0] bufWrAddr,
    input  logic [ActWidth-1:0]         bufWrData,
    actStreamIf.snk                     addrIn,
    output logic [ActWidth-1:0]         actData,
    output actPkg::actFlags_t           actFlags,
    output logic [actPkg::PatCntW-1:0]  actPatch,
    output logic [actPkg::GrpCntW-1:0]  actFtrGrp,
    output logic                        actValid,
    input  logic                        actReady,
    output logic                        layerDone
);

    localparam int Depth = 1 << actPkg::ActAddrW;

    logic [ActWidth-1:0] mem [Depth];
    logic [ActWidth-1:0] dataQ;
    actPkg::actAddr_t    infoQ;     // Side info of the item on the output
    actPkg::actAddr_t    skidQ;
    actPkg::actAddr_t    srcItem;
    logic                skidValid;
    logic                outFree;
    logic                load;

    assign addrIn.ready = !skidValid;
    assign srcItem      = skidValid ? skidQ : addrIn.payload;   // Skid drains first
    assign outFree      = !actValid || actReady;
    assign load         = (skidValid || addrIn.valid) && outFree;

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            actValid  <= 1'b0;
            skidValid <= 1'b0;
            layerDone <= 1'b0;
        end else begin
            actValid  <= load || (actValid && !actReady);
            layerDone <= actValid && actReady && infoQ.flags.lastLay;
            if (skidValid) begin
                skidValid <= !outFree;
            end else begin
                skidValid <= addrIn.valid && !outFree;   // Output stalled
            end
        end
    end

    // RAM, read data held while the output is stalled
    always_ff @(posedge clk) begin
        if (bufWr) begin
            mem[bufWrAddr] <= bufWrData;
        end
        if (load) begin
            dataQ <= mem[srcItem.addr];
            infoQ <= srcItem;
        end
        if (!skidValid) begin
            skidQ <= addrIn.payload;
        end
    end

    assign actData   = dataQ;
    assign actFlags  = infoQ.flags;
    assign actPatch  = infoQ.pat;
    assign actFtrGrp = infoQ.grp;

    // Host writes only reach the RAM once the pipe has drained
    noWriteInFlight: assert property (@(posedge clk) disable iff (!rst_n)
        bufWr |-> !actValid && !skidValid);

endmodule

//--- verilog/actFetchTop.sv
// Activation fetch top level
// APB register block followed by the loop, address and buffer stages
`timescale 1ns/1ps

module actFetchTop #(
    parameter int ActWidth = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [11:0]                paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic [ActWidth-1:0]        actData,
    output logic                       actFirstRow,
    output logic                       actLastRow,
    output logic                       actValCol,
    output logic                       actValPsum,
    output logic                       actLastBlk,
    output logic                       actEvenFrm,
    output logic                       actLastLay,
    output logic [actPkg::PatCntW-1:0] actPatch,
    output logic [actPkg::GrpCntW-1:0] actFtrGrp,
    output logic                       actValid,
    input  logic                       actReady
);

    actPkg::loopCfg_t            cfg;
    actPkg::actFlags_t           actFlags;
    logic                        start;
    logic                        busy;
    logic                        layerDone;
    logic                        bufWr;
    logic [actPkg::ActAddrW-1:0] bufWrAddr;
    logic [ActWidth-1:0]         bufWrData;

    actStreamIf #(.PayloadT(actPkg::actIdx_t))  idxIf ();
    actStreamIf #(.PayloadT(actPkg::actAddr_t)) addrIf ();

    actCfgRegs #(.ActWidth(ActWidth)) uRegs (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .cfg(cfg), .start(start),
        .busy(busy), .layerDone(layerDone), .bufWr(bufWr), .bufWrAddr(bufWrAddr),
        .bufWrData(bufWrData)
    );

    actLoopCtrl uLoop (
        .clk(clk), .rst_n(rst_n), .start(start), .cfg(cfg), .busy(busy), .idxOut(idxIf)
    );

    actAddrGen uAddr (
        .clk(clk), .rst_n(rst_n), .cfg(cfg), .idxIn(idxIf), .addrOut(addrIf)
    );

    actBuffer #(.ActWidth(ActWidth)) uBuf (
        .clk(clk), .rst_n(rst_n), .bufWr(bufWr), .bufWrAddr(bufWrAddr),
        .bufWrData(bufWrData), .addrIn(addrIf), .actData(actData), .actFlags(actFlags),
        .actPatch(actPatch), .actFtrGrp(actFtrGrp), .actValid(actValid),
        .actReady(actReady), .layerDone(layerDone)
    );

    // Flag struct onto plain ports
    assign actFirstRow = actFlags.firstRow;
    assign actLastRow  = actFlags.lastRow;
    assign actValCol   = actFlags.valCol;
    assign actValPsum  = actFlags.valPsum;
    assign actLastBlk  = actFlags.lastBlk;
    assign actEvenFrm  = actFlags.evenFrm;
    assign actLastLay  = actFlags.lastLay;

endmodule

//--- dv/actRefModel.svh
// Reference model of the activation fetch engine
// Builds the expected output items of one layer, in loop order,
// from the loop configuration and the testbench copy of the buffer
`ifndef ACT_REF_MODEL_SVH
`define ACT_REF_MODEL_SVH

typedef struct packed {
    logic [DataW-1:0]           data;
    actPkg::actFlags_t          flags;
    logic [actPkg::PatCntW-1:0] pat;
    logic [actPkg::GrpCntW-1:0] grp;
} expItem_t;

expItem_t         expQ[$];          // Expected items, oldest first
logic [DataW-1:0] bufImage [512];   // Mirror of the activation buffer

function automatic void buildExpected(input actPkg::loopCfg_t c);
    int       rowLen;
    int       blkLen;
    int       numBlk;
    int       perPatch;
    int       nOuter;
    int       nInner;
    int       pat;
    int       grp;
    int       col;
    int       row;
    int       blk;
    int       frm;
    logic [8:0] addr;
    expItem_t it;
    expQ.delete();
    rowLen   = int'(c.lenRow) + 1;
    blkLen   = rowLen * rowLen;
    numBlk   = int'(c.numBlk) + 1;
    perPatch = blkLen * numBlk * (int'(c.numFrm) + 1);
    // Outer loop is the group loop when patches go first
    nOuter   = c.patchFirst ? int'(c.numFtrGrp) : int'(c.numPat);
    nInner   = c.patchFirst ? int'(c.numPat) : int'(c.numFtrGrp);
    for (int o = 0; o <= nOuter; o++) begin
        for (int i = 0; i <= nInner; i++) begin
            pat = c.patchFirst ? i : o;
            grp = c.patchFirst ? o : i;
            // Column runs fastest, so pos is the linear buffer position
            for (int pos = 0; pos < perPatch; pos++) begin
                col  = pos % rowLen;
                row  = (pos / rowLen) % rowLen;
                blk  = (pos / blkLen) % numBlk;
                frm  = pos / (blkLen * numBlk);
                addr = 9'((pos + int'(c.patStride) * pat) % 512);
                it.data           = bufImage[addr];
                it.pat            = 4'(pat);
                it.grp            = 4'(grp);
                it.flags.firstRow = (col == 0);
                it.flags.lastRow  = (col == rowLen - 1);
                it.flags.valCol   = (col >= 2);
                it.flags.valPsum  = (row >= 2);
                it.flags.lastBlk  = (col == rowLen - 1) && (row == rowLen - 1);
                it.flags.evenFrm  = (frm % 2 == 0);
                it.flags.lastLay  = (o == nOuter) && (i == nInner) && (pos == perPatch - 1);
                expQ.push_back(it);
            end
        end
    end
endfunction

`endif

//--- dv/actFetchTb.sv
// Testbench of the activation fetch engine
// Programs the engine over APB, fills the buffer with LFSR data and
// checks every output item against the reference model, with and
// without back-pressure on the output stream
`timescale 1ns/1ps

module actFetchTb;

    localparam int DataW     = 16;
    localparam int WaitLimit = 200;   // Cycles or polls per wait

    logic                       clk;
    logic                       rst_n;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [11:0]                paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic [DataW-1:0]           actData;
    logic                       actFirstRow;
    logic                       actLastRow;
    logic                       actValCol;
    logic                       actValPsum;
    logic                       actLastBlk;
    logic                       actEvenFrm;
    logic                       actLastLay;
    logic [actPkg::PatCntW-1:0] actPatch;
    logic [actPkg::GrpCntW-1:0] actFtrGrp;
    logic                       actValid;
    logic                       actReady;
    logic [15:0]                lfsr = 16'd5;

    `include "actRefModel.svh"

    actFetchTop #(.ActWidth(DataW)) UUT (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .actData(actData),
        .actFirstRow(actFirstRow), .actLastRow(actLastRow), .actValCol(actValCol),
        .actValPsum(actValPsum), .actLastBlk(actLastBlk), .actEvenFrm(actEvenFrm),
        .actLastLay(actLastLay), .actPatch(actPatch), .actFtrGrp(actFtrGrp),
        .actValid(actValid), .actReady(actReady)
    );

    always #5 clk = ~clk;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrStep();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrStep()};
        end
        return v;
    endfunction

    // ==============================
    // APB access without wait states
    // ==============================
    task automatic apbWrite(input logic [11:0] a, input logic [31:0] d);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        @(negedge clk);
        penable = 1'b1;   // Access phase
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] a, output logic [31:0] d);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        d       = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic checkReadback(input logic [11:0] a, input logic [31:0] mask);
        logic [31:0] v;
        logic [31:0] rd;
        v = randBits(32);
        apbWrite(a, v);
        apbRead(a, rd);
        assert (rd == (v & mask)) else stopOnError($sformatf(
            "[ERROR] %0t: register %h read %h, expected %h", $time, a, rd, v & mask));
    endtask

    task automatic fillBuffer();
        logic [15:0] w;
        for (int k = 0; k < 512; k++) begin
            w = 16'(randBits(16));
            bufImage[9'(k)] = w;
            apbWrite(12'(actPkg::BufBase + 4 * k), {16'h0, w});
        end
    endtask

    function automatic actPkg::loopCfg_t randomCfg(input logic order);
        actPkg::loopCfg_t c;
        c.lenRow     = 5'(2 + randBits(1));   // 3 or 4 columns
        c.numBlk     = 4'(randBits(1));
        c.numFrm     = 4'(randBits(2) % 3);
        c.numPat     = 4'(1 + randBits(1));
        c.numFtrGrp  = 4'(1 + randBits(1));
        c.patchFirst = order;
        c.patStride  = 9'(randBits(9));
        return c;
    endfunction

    task automatic writeCfg(input actPkg::loopCfg_t c);
        logic [31:0] geom;
        logic [31:0] loopReg;
        geom           = '0;
        geom[4:0]      = c.lenRow;
        geom[11:8]     = c.numBlk;
        geom[19:16]    = c.numFrm;
        loopReg        = '0;
        loopReg[3:0]   = c.numPat;
        loopReg[11:8]  = c.numFtrGrp;
        loopReg[16]    = c.patchFirst;
        apbWrite(actPkg::RegGeom, geom);
        apbWrite(actPkg::RegLoop, loopReg);
        apbWrite(actPkg::RegPatStride, {23'h0, c.patStride});
    endtask

    task automatic checkItem(input expItem_t got, input expItem_t e, input int n);
        assert (got.data == e.data) else stopOnError($sformatf(
            "[ERROR] %0t: item %0d data %h, expected %h", $time, n, got.data, e.data));
        assert (got.flags == e.flags) else stopOnError($sformatf(
            "[ERROR] %0t: item %0d flags %b, expected %b", $time, n, got.flags, e.flags));
        assert (got.pat == e.pat && got.grp == e.grp) else stopOnError($sformatf(
            "[ERROR] %0t: item %0d patch/group %0d/%0d, expected %0d/%0d",
            $time, n, got.pat, got.grp, e.pat, e.grp));
    endtask

    // ==============================
    // Output stream
    // ==============================
    task automatic runLayer(input logic stalls);
        int       idle;
        int       n;
        logic     held;
        expItem_t heldItem;
        expItem_t got;
        idle = 0;
        n    = 0;
        held = 1'b0;
        while (expQ.size() > 0) begin
            @(negedge clk);
            got.data  = actData;
            got.flags = {actFirstRow, actLastRow, actValCol, actValPsum,
                         actLastBlk, actEvenFrm, actLastLay};
            got.pat   = actPatch;
            got.grp   = actFtrGrp;
            if (held) begin
                assert (actValid && got == heldItem) else stopOnError($sformatf(
                    "[ERROR] %0t: output changed while stalled at item %0d", $time, n));
            end
            actReady = stalls ? (randBits(2) != 0) : 1'b1;   // About one stall in four
            if (actValid && actReady) begin
                checkItem(got, expQ.pop_front(), n);
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WaitLimit) begin
                    stopOnError($sformatf("Timeout: no output item for %0d cycles, %0d left",
                        WaitLimit, expQ.size()));
                end
            end
            held     = actValid && !actReady;
            heldItem = got;
        end
    endtask

    task automatic waitDone();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        @(negedge clk);
        actReady = 1'b0;   // Extra items stay held on the output
        while (!st[1]) begin
            apbRead(actPkg::RegStatus, st);
            assert (!actValid) else stopOnError($sformatf(
                "[ERROR] %0t: output item beyond the expected sequence", $time));
            polls++;
            if (polls > WaitLimit) begin
                stopOnError("Timeout: done bit was never set after the layer");
            end
        end
        assert (!st[0]) else stopOnError($sformatf(
            "[ERROR] %0t: busy still set together with done", $time));
    endtask

    task automatic runCase(input actPkg::loopCfg_t c, input logic stalls);
        logic [31:0] st;
        writeCfg(c);
        buildExpected(c);
        @(negedge clk);
        actReady = 1'b0;
        apbWrite(actPkg::RegCtrl, 32'h1);
        apbRead(actPkg::RegStatus, st);
        assert (st[1:0] == 2'b01) else stopOnError($sformatf(
            "[ERROR] %0t: status %b after start, expected busy and not done", $time, st[1:0]));
        runLayer(stalls);
        waitDone();
    endtask

    initial begin
        actPkg::loopCfg_t cfg;
        logic [31:0]      rd;
        clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        actReady = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        apbRead(actPkg::RegStatus, rd);
        assert (rd == 32'h0) else stopOnError($sformatf(
            "[ERROR] %0t: status %h after reset, expected idle", $time, rd));
        assert (!actValid) else stopOnError($sformatf(
            "[ERROR] %0t: actValid set after reset", $time));
        checkReadback(actPkg::RegGeom, 32'h000F_0F1F);
        checkReadback(actPkg::RegLoop, 32'h0001_0F0F);
        checkReadback(actPkg::RegPatStride, 32'h0000_01FF);

        fillBuffer();
        cfg = randomCfg(1'b1);          // Patch loop inside
        runCase(cfg, 1'b0);
        cfg = randomCfg(1'b0);          // Group loop inside
        runCase(cfg, 1'b0);

        // New buffer image, then back-pressure on both orders
        fillBuffer();
        cfg = randomCfg(1'b1);
        runCase(cfg, 1'b1);
        cfg = randomCfg(1'b0);
        runCase(cfg, 1'b1);

        $display("TEST OK");
        $finish;
    end

endmodule

//--- build.f
+incdir+dv
common/actPkg.sv
common/actStreamIf.sv
verilog/actCfgRegs.sv
actCtrl/actLoopCtrl.sv
actCtrl/actAddrGen.sv
verilog/actBuffer.sv
verilog/actFetchTop.sv
dv/actFetchTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the activation fetch testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module actFetchTb

# The exit status of the pipe is the one of tee, the log decides
./obj_dir/VactFetchTb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a pass line"
    exit 1
fi
